// ==== verilog.f ====
design/fetch_pkg.sv
design/fetch_fifo.sv
design/fetch_pcgen.sv
design/fetch_align.sv
design/fetch_predecode.sv
design/fetch_top.sv
testbench/fetch_chk.sv
testbench/fetch_tb.sv

// ==== testbench/fetch_tb.sv ====
// testbench for the fetch front end
// random instruction memory with forward jal and c.j jumps
// in-order cache model with random latency
// decode credit return with stalls, backend redirects
// reference walk checked against every valid lane

`default_nettype none

module fetch_tb;

    import fetch_pkg::*;

    localparam int MEM_HW     = 16384;              // half-words of instruction memory
    localparam int N_CHECK    = 400;
    localparam int TIMEOUT    = N_CHECK * 30;
    localparam int N_REDIR    = 3;
    localparam int REDIR_SPAN = 2000;               // redirect targets among the first starts

    logic                      clk;
    logic                      rst;
    ic_resp_t                  ic_resp;
    redir_t                    be_redir;
    logic [FW_CNT_W-1:0]       credit_ret;
    ic_req_t                   ic_req;
    fet_bundle_t [FETCH_W-1:0] out_bundle;
    logic [FETCH_W-1:0]        out_valid;

    logic [15:0]       mem [MEM_HW];
    bit                jmp [MEM_HW];                // jal or c.j starts here
    logic [ADDR_W-1:0] tgt [MEM_HW];
    int unsigned       starts [$];                  // half-word index of each instruction
    logic [ADDR_W-1:0] pend_addr [$];
    int unsigned       pend_due [$];
    int unsigned       last_due;
    int                seed;
    int unsigned       cycle;
    int unsigned       checked;
    int unsigned       owed;                        // credits decode still holds back
    int unsigned       stall_left;
    int unsigned       redirects;
    int unsigned       next_redir;
    logic [ADDR_W-1:0] exp_pc;
    logic [ADDR_W-1:0] redir_pc;
    bit                after_redir;

    fetch_top fetch_top_i (
        .clk(clk), .rst(rst), .ic_resp(ic_resp), .be_redir(be_redir),
        .credit_ret(credit_ret), .ic_req(ic_req), .out_bundle(out_bundle),
        .out_valid(out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int unsigned rand_below(int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "simulation stopped");
    endtask

    function automatic logic [LINE_W-1:0] line_data(logic [ADDR_W-1:0] addr);
        logic [LINE_W-1:0] d;
        int unsigned       base;
        base = addr >> 1;
        for (int i = 0; i < LINE_HW; i++) begin
            d[i*HW_W +: HW_W] = mem[(base + i) % MEM_HW];   // lowest half-word first
        end
        return d;
    endfunction

    // lay out instruction sizes first, then encode with known jump targets
    task automatic build_memory();
        int unsigned       kind [$];                // 0 rvc, 1 32-bit, 2 c.j, 3 jal
        int unsigned       hw;
        int unsigned       k;
        int unsigned       d;
        logic [ADDR_W-1:0] pc;
        logic [ADDR_W-1:0] off;
        logic [31:0]       w;
        for (int i = 0; i < MEM_HW; i++) begin
            mem[i] = 16'(i) ^ 16'hc3c0;
        end
        hw = RESET_PC >> 1;
        while (hw + 8 < MEM_HW) begin
            k = rand_below(16);
            k = (k == 0) ? 3 : (k == 1) ? 2 : (k < 9) ? 0 : 1;
            starts.push_back(hw);
            kind.push_back(k);
            hw += (k == 1 || k == 3) ? 2 : 1;
        end
        foreach (starts[n]) begin
            hw  = starts[n];
            pc  = ADDR_W'(hw * 2);
            d   = 1 + rand_below(8);                // forward, sometimes the fall-through
            k   = kind[n];
            off = '0;
            if (k >= 2 && n + d >= starts.size()) k = k - 2;
            w = $random(seed);
            case (k)
                0: begin
                    if (w[1:0] == 2'b11) w[1:0] = 2'b00;
                    if (w[1:0] == CJ_QUAD && w[15:13] == CJ_FUNCT3) w[15:13] = 3'b000;
                end
                1: begin
                    w[1:0] = 2'b11;
                    if (w[6:0] == OP_JAL) w[3] = 1'b0;      // becomes jalr
                end
                2: begin
                    off = ADDR_W'(starts[n + d] * 2) - pc;
                    w[15:0] = {CJ_FUNCT3, off[11], off[4], off[9:8], off[10], off[6],
                               off[7], off[3:1], off[5], CJ_QUAD};
                end
                default: begin
                    off = ADDR_W'(starts[n + d] * 2) - pc;
                    w = {off[20], off[10:1], off[11], off[19:12], w[11:7], OP_JAL};
                end
            endcase
            mem[hw] = w[15:0];
            if (k == 1 || k == 3) mem[hw + 1] = w[31:16];
            if (k >= 2) begin
                jmp[hw] = 1'b1;
                tgt[hw] = pc + off;
            end
        end
    endtask

    task automatic answer_cache();
        ic_resp = '0;
        if (pend_addr.size() != 0 && cycle >= pend_due[0]) begin
            ic_resp.valid = 1'b1;
            ic_resp.data  = line_data(pend_addr.pop_front());
            void'(pend_due.pop_front());
        end
    endtask

    task automatic return_credits();
        int unsigned ret;
        ret = 0;
        if (stall_left != 0) begin
            stall_left--;
        end else if (rand_below(20) == 0) begin
            stall_left = 10 + rand_below(20);       // decode stops returning for a while
        end else begin
            ret = rand_below(FETCH_W + 1);
            if (ret > owed) ret = owed;
        end
        owed -= ret;
        credit_ret = FW_CNT_W'(ret);
    endtask

    task automatic drive_redirect();
        be_redir = '0;
        if (redirects < N_REDIR && checked >= next_redir) begin
            be_redir.valid = 1'b1;
            be_redir.pc    = ADDR_W'(starts[rand_below(REDIR_SPAN)] * 2);
            redirects++;
            next_redir += 60 + rand_below(50);
        end
    endtask

    task automatic record_request();
        int unsigned due;
        if (ic_req.valid) begin
            due = cycle + 1 + rand_below(5);
            if (due <= last_due) due = last_due + 1;    // answers stay in order
            pend_addr.push_back(ic_req.addr);
            pend_due.push_back(due);
            last_due = due;
        end
    endtask

    task automatic check_lanes();
        int unsigned       idx;
        int unsigned       size;
        logic [31:0]       exp_ir;
        logic [ADDR_W-1:0] exp_next;
        logic              exp_rvc;
        for (int i = 0; i < FETCH_W; i++) begin
            if (out_valid[i]) begin
                idx      = (exp_pc >> 1) % MEM_HW;
                size     = (mem[idx][1:0] == 2'b11) ? 4 : 2;
                exp_ir   = (size == 4) ? {mem[(idx + 1) % MEM_HW], mem[idx]} : {16'h0, mem[idx]};
                exp_next = jmp[idx] ? tgt[idx] : exp_pc + size;
                exp_rvc  = (size == 2);
                if (after_redir) begin
                    assert (out_bundle[i].pc == redir_pc) else report_failure($sformatf(
                        "Error: out_bundle[%0d].pc after redirect is 0x%h, expected 0x%h",
                        i, out_bundle[i].pc, redir_pc));
                    after_redir = 1'b0;
                end
                assert (out_bundle[i].pc == exp_pc) else report_failure($sformatf(
                    "Error: out_bundle[%0d].pc is 0x%h, expected 0x%h",
                    i, out_bundle[i].pc, exp_pc));
                assert (out_bundle[i].ir == exp_ir) else report_failure($sformatf(
                    "Error: out_bundle[%0d].ir is 0x%h, expected 0x%h",
                    i, out_bundle[i].ir, exp_ir));
                assert (out_bundle[i].is_rvc == exp_rvc) else report_failure($sformatf(
                    "Error: out_bundle[%0d].is_rvc is 0x%h, expected 0x%h",
                    i, out_bundle[i].is_rvc, exp_rvc));
                assert (out_bundle[i].is_jump == jmp[idx]) else report_failure($sformatf(
                    "Error: out_bundle[%0d].is_jump is 0x%h, expected 0x%h",
                    i, out_bundle[i].is_jump, jmp[idx]));
                assert (out_bundle[i].pnpc == exp_next) else report_failure($sformatf(
                    "Error: out_bundle[%0d].pnpc is 0x%h, expected 0x%h",
                    i, out_bundle[i].pnpc, exp_next));
                exp_pc = exp_next;
                checked++;
            end
        end
    endtask

    initial begin
        seed        = 32'ha188;
        rst         = 1'b1;
        ic_resp     = '0;
        be_redir    = '0;
        credit_ret  = '0;
        cycle       = 0;
        checked     = 0;
        owed        = 0;
        stall_left  = 0;
        redirects   = 0;
        last_due    = 0;
        exp_pc      = RESET_PC;
        redir_pc    = RESET_PC;
        after_redir = 1'b0;
        build_memory();
        next_redir = 40 + rand_below(60);
        repeat (10) @(negedge clk);
        rst = 1'b0;
        while (checked < N_CHECK) begin
            cycle++;
            if (cycle > TIMEOUT) begin
                report_failure($sformatf("timeout after %0d cycles with %0d instructions checked",
                                         TIMEOUT, checked));
            end
            if (fetch_top_i.chk_i.errors != 0) begin
                report_failure("protocol checker flagged a violation");
            end
            answer_cache();
            return_credits();
            drive_redirect();
            #1;                                     // outputs settle before the next rising edge
            if (be_redir.valid) begin
                assert (out_valid == '0) else report_failure($sformatf(
                    "Error: out_valid in redirect cycle is 0x%h, expected 0x0", out_valid));
                exp_pc      = be_redir.pc;
                redir_pc    = be_redir.pc;
                after_redir = 1'b1;
            end
            check_lanes();
            owed += $countones(out_valid);
            record_request();
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        if (fetch_top_i.chk_i.errors == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            report_failure("protocol checker flagged a violation");
        end
    end

endmodule

`default_nettype wire

// ==== testbench/fetch_chk.sv ====
// protocol checker bound to the fetch top level
// credit limit and contiguous lanes toward decode
// line-aligned requests and in-flight limit toward the cache
// quiet outputs during reset

`default_nettype none

module fetch_chk (
    input logic                           clk,
    input logic                           rst,
    input fetch_pkg::ic_req_t             ic_req,
    input fetch_pkg::ic_resp_t            ic_resp,
    input logic [fetch_pkg::FW_CNT_W-1:0] credit_ret,
    input logic [fetch_pkg::FETCH_W-1:0]  out_valid
);

    import fetch_pkg::*;

    int   held;                 // credits fetch may still spend
    int   inflight;             // requests not answered yet
    int   errors   = 0;
    logic rst_seen = 1'b0;

    always @(posedge clk) begin
        rst_seen <= rst;
        if (rst) begin
            held     <= OUT_CREDITS;
            inflight <= 0;
        end else begin
            held     <= held - $countones(out_valid) + int'(credit_ret);
            inflight <= inflight + int'(ic_req.valid) - int'(ic_resp.valid);
        end
    end

    credit_limit: assert property (@(posedge clk) disable iff (rst)
        $countones(out_valid) <= held)
    else begin
        $error("more lanes valid than credits held");
        errors++;
    end

    lanes_contiguous: assert property (@(posedge clk) disable iff (rst)
        (out_valid & (out_valid + 1'b1)) == '0)
    else begin
        $error("valid lanes do not start at lane 0");
        errors++;
    end

    req_aligned: assert property (@(posedge clk) disable iff (rst)
        ic_req.valid |-> ic_req.addr[LINE_OFF_W:0] == '0)
    else begin
        $error("cache request address not line aligned");
        errors++;
    end

    inflight_limit: assert property (@(posedge clk) disable iff (rst)
        inflight + int'(ic_req.valid) <= LINE_Q_DEPTH)
    else begin
        $error("too many cache requests in flight");
        errors++;
    end

    quiet_in_reset: assert property (@(posedge clk)
        (rst && rst_seen) |-> (out_valid == '0 && !ic_req.valid))
    else begin
        $error("outputs active during reset");
        errors++;
    end

endmodule

bind fetch_top fetch_chk chk_i (
    .clk(clk), .rst(rst), .ic_req(ic_req), .ic_resp(ic_resp),
    .credit_ret(credit_ret), .out_valid(out_valid)
);

`default_nettype wire

// ==== design/fetch_top.sv ====
// fetch front end top level
// pc generator, line queue, aligner, predecoder, instruction queue
// downstream credit counter and output valid generation

`default_nettype none

module fetch_top (
    input  logic                                            clk,
    input  logic                                            rst,
    input  fetch_pkg::ic_resp_t                             ic_resp,
    input  fetch_pkg::redir_t                               be_redir,
    input  logic [fetch_pkg::FW_CNT_W-1:0]                  credit_ret,
    output fetch_pkg::ic_req_t                              ic_req,
    output fetch_pkg::fet_bundle_t [fetch_pkg::FETCH_W-1:0] out_bundle,
    output logic [fetch_pkg::FETCH_W-1:0]                   out_valid
);

    import fetch_pkg::*;

    line_t                          lq_push;
    logic                           lq_push_n;
    logic                           lq_flush;
    line_t [LQ_WIN-1:0]             lq_head;
    logic [LQ_CNT_W-1:0]            lq_count;
    logic                           line_pop;
    logic [$clog2(LQ_WIN+1)-1:0]    lq_pop_n;
    redir_t                         fe_redir;
    logic [FETCH_W-1:0][ADDR_W-1:0] inst_pc;
    logic [FETCH_W-1:0][31:0]       inst_ir;
    logic [FETCH_W-1:0]             inst_rvc;
    logic [FW_CNT_W-1:0]            inst_n;
    fet_bundle_t [FETCH_W-1:0]      pd_bundles;
    logic [FW_CNT_W-1:0]            keep_n;
    logic [IQ_CNT_W-1:0]            iq_count;
    logic [IQ_CNT_W-1:0]            room;
    logic [FW_CNT_W-1:0]            pop;
    logic [CRED_W-1:0]              credits;

    assign lq_pop_n = $bits(lq_pop_n)'(line_pop);      // at most one line per cycle
    assign room     = IQ_CNT_W'(INST_Q_DEPTH) - iq_count;

    fetch_pcgen pcgen_i (
        .clk(clk), .rst(rst), .be_redir(be_redir), .fe_redir(fe_redir),
        .ic_resp(ic_resp), .lq_count(lq_count), .ic_req(ic_req),
        .lq_push(lq_push), .lq_push_n(lq_push_n), .lq_flush(lq_flush)
    );

    fetch_fifo #(.payload_t(line_t), .DEPTH(LINE_Q_DEPTH), .PUSH_W(1), .POP_W(LQ_WIN)) line_q_i (
        .clk(clk), .rst(rst), .flush(lq_flush), .push_n(lq_push_n), .push_data(lq_push),
        .pop_n(lq_pop_n), .head(lq_head), .count(lq_count)
    );

    fetch_align align_i (
        .clk(clk), .rst(rst), .flush(lq_flush), .lines(lq_head), .line_count(lq_count),
        .room(room), .inst_pc(inst_pc), .inst_ir(inst_ir), .inst_rvc(inst_rvc),
        .inst_n(inst_n), .line_pop(line_pop)
    );

    fetch_predecode predecode_i (
        .inst_pc(inst_pc), .inst_ir(inst_ir), .inst_rvc(inst_rvc), .inst_n(inst_n),
        .bundles(pd_bundles), .keep_n(keep_n), .fe_redir(fe_redir)
    );

    fetch_fifo #(.payload_t(fet_bundle_t), .DEPTH(INST_Q_DEPTH), .PUSH_W(FETCH_W),
                 .POP_W(FETCH_W)) inst_q_i (
        .clk(clk), .rst(rst), .flush(be_redir.valid), .push_n(keep_n), .push_data(pd_bundles),
        .pop_n(pop), .head(out_bundle), .count(iq_count)
    );

    // send min(queued, credits, width), nothing while the backend redirects
    always_comb begin
        pop = FW_CNT_W'(FETCH_W);
        if (iq_count < pop) pop = FW_CNT_W'(iq_count);
        if (credits < pop) pop = FW_CNT_W'(credits);
        if (be_redir.valid) pop = '0;
        for (int i = 0; i < FETCH_W; i++) begin
            out_valid[i] = i < pop;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CRED_W'(OUT_CREDITS);
        end else begin
            credits <= credits - CRED_W'(pop) + CRED_W'(credit_ret);   // kept across redirects
        end
    end

endmodule

`default_nettype wire

// ==== design/fetch_predecode.sv ====
// predecoder for the aligned fetch group
// finds jal and c.j, decodes their targets
// fills predicted next pc per lane
// truncates the group after the first jump and raises a redirect

`default_nettype none

module fetch_predecode (
    input  logic [fetch_pkg::FETCH_W-1:0][fetch_pkg::ADDR_W-1:0] inst_pc,
    input  logic [fetch_pkg::FETCH_W-1:0][31:0]                  inst_ir,
    input  logic [fetch_pkg::FETCH_W-1:0]                        inst_rvc,
    input  logic [fetch_pkg::FW_CNT_W-1:0]                       inst_n,
    output fetch_pkg::fet_bundle_t [fetch_pkg::FETCH_W-1:0]      bundles,
    output logic [fetch_pkg::FW_CNT_W-1:0]                       keep_n,
    output fetch_pkg::redir_t                                    fe_redir
);

    import fetch_pkg::*;

    logic [FETCH_W-1:0]             jal;
    logic [FETCH_W-1:0]             cj;
    logic [FETCH_W-1:0][ADDR_W-1:0] imm;
    logic [FETCH_W-1:0][ADDR_W-1:0] target;
    logic [FETCH_W-1:0][ADDR_W-1:0] seq;        // fall-through pc
    logic                           cut;

    always_comb begin
        for (int i = 0; i < FETCH_W; i++) begin
            jal[i] = !inst_rvc[i] && inst_ir[i][6:0] == OP_JAL;
            cj[i]  = inst_rvc[i] && inst_ir[i][15:13] == CJ_FUNCT3 && inst_ir[i][1:0] == CJ_QUAD;
            if (cj[i]) begin
                imm[i] = {{(ADDR_W - 12){inst_ir[i][12]}}, inst_ir[i][12], inst_ir[i][8],
                          inst_ir[i][10:9], inst_ir[i][6], inst_ir[i][7], inst_ir[i][2],
                          inst_ir[i][11], inst_ir[i][5:3], 1'b0};
            end else begin
                imm[i] = {{(ADDR_W - 21){inst_ir[i][31]}}, inst_ir[i][31], inst_ir[i][19:12],
                          inst_ir[i][20], inst_ir[i][30:21], 1'b0};
            end
            target[i] = inst_pc[i] + imm[i];
            seq[i]    = inst_pc[i] + (inst_rvc[i] ? ADDR_W'(2) : ADDR_W'(4));

            bundles[i].pc      = inst_pc[i];
            bundles[i].ir      = inst_ir[i];
            bundles[i].is_rvc  = inst_rvc[i];
            bundles[i].is_jump = jal[i] || cj[i];
            bundles[i].pnpc    = (jal[i] || cj[i]) ? target[i] : seq[i];
        end
    end

    // keep lanes up to and including the first jump
    always_comb begin
        keep_n   = '0;
        cut      = 1'b0;
        fe_redir = '0;
        for (int i = 0; i < FETCH_W; i++) begin
            if (!cut && i < inst_n) begin
                keep_n = keep_n + 1'b1;
                if (jal[i] || cj[i]) begin
                    cut = 1'b1;
                    // a last-lane jump to its own fall-through needs no restart
                    if (i != inst_n - 1 || target[i] != seq[i]) begin
                        fe_redir.valid = 1'b1;
                        fe_redir.pc    = target[i];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/fetch_align.sv ====
// instruction aligner
// cuts 16-bit and 32-bit instructions out of the two head lines
// handles instructions that cross a line boundary
// tracks the half-word offset and pops consumed lines

`default_nettype none

module fetch_align (
    input  logic                                              clk,
    input  logic                                              rst,
    input  logic                                              flush,
    input  fetch_pkg::line_t [fetch_pkg::LQ_WIN-1:0]          lines,
    input  logic [fetch_pkg::LQ_CNT_W-1:0]                    line_count,
    input  logic [fetch_pkg::IQ_CNT_W-1:0]                    room,
    output logic [fetch_pkg::FETCH_W-1:0][fetch_pkg::ADDR_W-1:0] inst_pc,
    output logic [fetch_pkg::FETCH_W-1:0][31:0]               inst_ir,
    output logic [fetch_pkg::FETCH_W-1:0]                     inst_rvc,
    output logic [fetch_pkg::FW_CNT_W-1:0]                    inst_n,
    output logic                                              line_pop
);

    import fetch_pkg::*;

    logic [LINE_OFF_W-1:0]                off;      // offset inside head line
    logic [LINE_OFF_W-1:0]                eff;
    logic [2*LINE_HW-1:0][HW_W-1:0]       win;      // head line in the low half
    logic [POS_W-1:0]                     avail;    // half-words present
    logic [FETCH_W:0][POS_W-1:0]          pos;      // instruction starts
    logic [FETCH_W-1:0]                   big;      // 32-bit encoding
    logic [FW_CNT_W-1:0]                  n;
    logic [POS_W-1:0]                     fin;
    logic                                 stop;

    always_comb begin
        win = {lines[1].data, lines[0].data};
        // the start field only matters for the first line after a redirect
        eff = (off > lines[0].start) ? off : lines[0].start;
        if (line_count >= LQ_CNT_W'(2)) begin
            avail = POS_W'(2 * LINE_HW);
        end else if (line_count == LQ_CNT_W'(1)) begin
            avail = POS_W'(LINE_HW);
        end else begin
            avail = '0;
        end
        pos[0] = POS_W'(eff);
        n      = '0;
        stop   = flush;
        for (int i = 0; i < FETCH_W; i++) begin
            big[i]     = win[pos[i]][1:0] == 2'b11;
            pos[i + 1] = pos[i] + (big[i] ? POS_W'(2) : POS_W'(1));
            if (!stop && pos[i + 1] <= avail && i < room) begin
                n = n + 1'b1;
            end else begin
                stop = 1'b1;                              // lanes stay contiguous
            end
        end
        fin = pos[n];
    end

    always_comb begin
        for (int i = 0; i < FETCH_W; i++) begin
            inst_pc[i]  = lines[0].pc + ADDR_W'({pos[i], 1'b0});
            inst_ir[i]  = big[i] ? {win[pos[i] + 1'b1], win[pos[i]]} : {16'h0, win[pos[i]]};
            inst_rvc[i] = !big[i];
        end
    end

    assign inst_n   = n;
    assign line_pop = fin >= POS_W'(LINE_HW);          // head line used up

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            off <= '0;
        end else if (line_pop) begin
            off <= LINE_OFF_W'(fin - POS_W'(LINE_HW));   // roll into next line
        end else if (n != '0) begin
            off <= LINE_OFF_W'(fin);
        end
    end

endmodule

`default_nettype wire

// ==== design/fetch_pcgen.sv ====
// fetch pc generation
// redirect selection, backend over frontend
// registered cache request under line queue credits
// in-flight and stale response counting, line tagging

`default_nettype none

module fetch_pcgen (
    input  logic                             clk,
    input  logic                             rst,
    input  fetch_pkg::redir_t                be_redir,
    input  fetch_pkg::redir_t                fe_redir,
    input  fetch_pkg::ic_resp_t              ic_resp,
    input  logic [fetch_pkg::LQ_CNT_W-1:0]   lq_count,
    output fetch_pkg::ic_req_t               ic_req,
    output fetch_pkg::line_t                 lq_push,
    output logic                             lq_push_n,
    output logic                             lq_flush
);

    import fetch_pkg::*;

    redir_t                fe_q;        // frontend redirect, one cycle late
    redir_t                redir;       // redirect taken this cycle
    logic [ADDR_W-1:0]     tgt_line;
    logic [ADDR_W-1:0]     next_addr;   // next line to request
    logic [ADDR_W-1:0]     resp_pc;     // line of the oldest kept request
    logic [LINE_OFF_W-1:0] resp_start;
    logic [LQ_CNT_W-1:0]   inflight;
    logic [LQ_CNT_W-1:0]   drop;        // stale responses still to come
    logic [LQ_CNT_W-1:0]   lq_used;
    logic                  issue;
    logic                  keep;

    always_comb begin
        redir = fe_q;
        if (be_redir.valid) redir = be_redir;
    end

    assign tgt_line = redir.pc & LINE_MASK;
    assign lq_flush = redir.valid;
    assign lq_used  = redir.valid ? '0 : lq_count;   // queue is emptied this cycle
    assign issue    = (inflight + lq_used) < LINE_Q_DEPTH;
    assign keep     = ic_resp.valid && drop == '0 && !redir.valid;

    assign lq_push.pc    = resp_pc;
    assign lq_push.start = resp_start;
    assign lq_push.data  = ic_resp.data;
    assign lq_push_n     = keep;

    always_ff @(posedge clk) begin
        if (rst) begin
            fe_q       <= '0;
            ic_req     <= '0;
            next_addr  <= RESET_PC & LINE_MASK;
            resp_pc    <= RESET_PC & LINE_MASK;
            resp_start <= RESET_PC[LINE_OFF_W:1];
            inflight   <= '0;
            drop       <= '0;
        end else begin
            fe_q         <= be_redir.valid ? '0 : fe_redir;
            ic_req.valid <= issue;
            ic_req.addr  <= redir.valid ? tgt_line : next_addr;
            inflight     <= inflight + LQ_CNT_W'(issue) - LQ_CNT_W'(ic_resp.valid);
            if (redir.valid) begin
                next_addr  <= issue ? tgt_line + LINE_BYTES : tgt_line;
                resp_pc    <= tgt_line;
                resp_start <= redir.pc[LINE_OFF_W:1];   // half-word of the target
                drop       <= inflight - LQ_CNT_W'(ic_resp.valid);
            end else begin
                if (issue) next_addr <= next_addr + LINE_BYTES;
                if (keep) begin
                    resp_pc    <= resp_pc + LINE_BYTES;
                    resp_start <= '0;                   // later lines start at 0
                end
                if (ic_resp.valid && drop != '0) drop <= drop - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/fetch_fifo.sv ====
// circular queue with a type parameter for the payload
// multi-lane push behind the tail, multi-lane pop from the front
// combinational head window and occupancy count

`default_nettype none

module fetch_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4,       // power of two, index wraps naturally
    parameter int  PUSH_W    = 1,
    parameter int  POP_W     = 1
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         flush,
    input  logic [$clog2(PUSH_W+1)-1:0]  push_n,
    input  payload_t [PUSH_W-1:0]        push_data,
    input  logic [$clog2(POP_W+1)-1:0]   pop_n,
    output payload_t [POP_W-1:0]         head,
    output logic [$clog2(DEPTH+1)-1:0]   count
);

    typedef logic [$clog2(DEPTH)-1:0]   idx_t;
    typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

    payload_t mem [DEPTH];
    idx_t     front;
    idx_t     tail;
    cnt_t     num;

    assign tail  = front + idx_t'(num);
    assign count = num;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            front <= '0;
            num   <= '0;
        end else begin
            front <= front + idx_t'(pop_n);
            num   <= num + cnt_t'(push_n) - cnt_t'(pop_n);   // caller keeps this in range
        end
    end

    // entries land behind the tail, lane 0 first
    always_ff @(posedge clk) begin
        for (int i = 0; i < PUSH_W; i++) begin
            if (i < push_n) begin
                mem[tail + idx_t'(i)] <= push_data[i];
            end
        end
    end

    // look-ahead window, lanes past count are stale
    always_comb begin
        for (int i = 0; i < POP_W; i++) begin
            head[i] = mem[front + idx_t'(i)];
        end
    end

endmodule

`default_nettype wire

// ==== design/fetch_pkg.sv ====
// fetch front end shared definitions
// widths, queue depths, credits and the reset pc
// jal and c.j encodings
// line, fetch bundle, cache and redirect structs

`default_nettype none

package fetch_pkg;

    localparam int ADDR_W       = 32;
    localparam int HW_W         = 16;                       // one half-word
    localparam int LINE_HW      = 4;                        // half-words per cache line
    localparam int LINE_W       = LINE_HW * HW_W;
    localparam int LINE_BYTES   = LINE_HW * 2;
    localparam int LINE_OFF_W   = $clog2(LINE_HW);          // half-word index in a line
    localparam int POS_W        = LINE_OFF_W + 2;           // position in the two-line window
    localparam int FETCH_W      = 2;                        // instructions per cycle
    localparam int FW_CNT_W     = $clog2(FETCH_W + 1);
    localparam int LINE_Q_DEPTH = 4;                        // also caps requests in flight
    localparam int LQ_CNT_W     = $clog2(LINE_Q_DEPTH + 1);
    localparam int LQ_WIN       = 2;                        // head lines seen by the aligner
    localparam int INST_Q_DEPTH = 8;
    localparam int IQ_CNT_W     = $clog2(INST_Q_DEPTH + 1);
    localparam int OUT_CREDITS  = 4;                        // granted by decode after reset
    localparam int CRED_W       = $clog2(OUT_CREDITS + 1);

    localparam logic [ADDR_W-1:0] RESET_PC  = 32'h0000_0100;
    localparam logic [ADDR_W-1:0] LINE_MASK = ~ADDR_W'(LINE_BYTES - 1);

    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [2:0] CJ_FUNCT3 = 3'b101;              // c.j in quadrant 1
    localparam logic [1:0] CJ_QUAD   = 2'b01;

    typedef struct packed {
        logic [ADDR_W-1:0]     pc;      // line base
        logic [LINE_OFF_W-1:0] start;   // first half-word, only after a redirect
        logic [LINE_W-1:0]     data;
    } line_t;

    typedef struct packed {
        logic [ADDR_W-1:0] pc;
        logic [31:0]       ir;          // upper half zero when compressed
        logic              is_rvc;
        logic              is_jump;
        logic [ADDR_W-1:0] pnpc;        // predicted next pc
    } fet_bundle_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;        // line aligned
    } ic_req_t;

    typedef struct packed {
        logic              valid;
        logic [LINE_W-1:0] data;
    } ic_resp_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] pc;
    } redir_t;

endpackage

`default_nettype wire
